//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_acc_top
FILELIST = filelist.f
PASS_MSG = Simulation PASSED

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- acc_conf_pkg.sv
`default_nettype none

package acc_conf_pkg;

  // Field widths.
  localparam int ADDR_W = 32;
  localparam int QTD_W  = 16;

  // Bit positions in conf_valid.
  localparam int CONF_QUEUE_BIT = 0;
  localparam int CONF_DSM_BIT   = 1;

  // Queue view with the base address in the low bits.
  typedef struct packed {
    logic [15:0]       queue_id;
    logic [QTD_W-1:0]  count;
    logic [ADDR_W-1:0] base_addr;
  } queue_conf_t;

  // Status record view.
  typedef struct packed {
    logic [31:0]       reserved;
    logic [ADDR_W-1:0] status_addr;
  } dsm_conf_t;

  typedef union packed {
    queue_conf_t queue_conf;
    dsm_conf_t   dsm_conf;
  } conf_word_t;

endpackage

`default_nettype wire

//--- acc_mem_pkg.sv
`default_nettype none

package acc_mem_pkg;

  // Request tag carried with every request and answered back.
  localparam int TAG_W = 8;

  typedef logic [TAG_W-1:0] tag_t;

  // Status record fields from low to high are write_beats, read_beats and acc_id.
  localparam int STAT_FIELD_W = 16;
  localparam int STAT_W       = 3 * STAT_FIELD_W;

endpackage

`default_nettype wire

//--- acc_top.sv
`default_nettype none

module acc_top
  import acc_conf_pkg::*;
  import acc_mem_pkg::*;
#(
  parameter int DATA_WIDTH   = 32,
  parameter int ACC_ID       = 7,
  parameter int IN_QUEUE_ID  = 0,
  parameter int OUT_QUEUE_ID = 1
) (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic                                   start,
  input  logic [1:0]                             conf_valid,
  input  conf_word_t                             conf,
  input  logic                                   available_read,
  output logic                                   request_read,
  output logic [TAG_W+ADDR_W-1:0]                request_data,
  input  logic                                   read_data_valid,
  input  tag_t                                   read_queue_id,
  input  logic [DATA_WIDTH-1:0]                  read_data,
  input  logic [1:0]                             available_write,
  output logic [1:0]                             request_write,
  output logic [2*(DATA_WIDTH+ADDR_W+TAG_W)-1:0] write_data,
  input  logic                                   write_data_valid,
  input  tag_t                                   write_queue_id
);

  localparam int WR_W = DATA_WIDTH + ADDR_W + TAG_W;

  logic                  start_q;
  logic [1:0]            conf_valid_q;
  conf_word_t            conf_q;
  logic                  read_data_valid_q;
  tag_t                  read_queue_id_q;
  logic [DATA_WIDTH-1:0] read_data_q;
  logic                  write_data_valid_q;
  tag_t                  write_queue_id_q;

  logic                  acc_user_available_read;
  logic                  acc_user_request_read;
  logic [DATA_WIDTH-1:0] acc_user_read_data;
  logic                  acc_user_available_write;
  logic                  acc_user_request_write;
  logic [DATA_WIDTH-1:0] acc_user_write_data;
  logic                  has_rd_pending;
  logic                  has_wr_pending;
  logic                  has_pending;
  logic                  in_done;
  logic                  out_done;

  // ********************************************************************
  // Input register stage.
  // ********************************************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      start_q            <= 1'b0;
      conf_valid_q       <= '0;
      read_data_valid_q  <= 1'b0;
      write_data_valid_q <= 1'b0;
    end else begin
      start_q            <= start;
      conf_valid_q       <= conf_valid;
      read_data_valid_q  <= read_data_valid;
      write_data_valid_q <= write_data_valid;
    end
  end

  always_ff @(posedge clk) begin
    conf_q           <= conf;
    read_queue_id_q  <= read_queue_id;
    read_data_q      <= read_data;
    write_queue_id_q <= write_queue_id;
  end

  assign has_pending = has_rd_pending | has_wr_pending;

  // ********************************************************************
  // Queues, kernel and status record.
  // ********************************************************************

  input_queue_ctrl #(
    .DATA_WIDTH (DATA_WIDTH),
    .ID_QUEUE   (IN_QUEUE_ID)
  ) u_in_queue (
    .clk                     (clk),
    .arst_n                  (arst_n),
    .start                   (start_q),
    .conf_valid              (conf_valid_q),
    .conf                    (conf_q),
    .available_read          (available_read),
    .read_data_valid         (read_data_valid_q),
    .read_queue_id           (read_queue_id_q),
    .read_data               (read_data_q),
    .acc_user_request_read   (acc_user_request_read),
    .request_read            (request_read),
    .request_data            (request_data),
    .has_rd_pending          (has_rd_pending),
    .acc_user_available_read (acc_user_available_read),
    .acc_user_read_data      (acc_user_read_data),
    .done                    (in_done)
  );

  output_queue_ctrl #(
    .DATA_WIDTH (DATA_WIDTH),
    .ID_QUEUE   (OUT_QUEUE_ID)
  ) u_out_queue (
    .clk                      (clk),
    .arst_n                   (arst_n),
    .start                    (start_q),
    .conf_valid               (conf_valid_q),
    .conf                     (conf_q),
    .available_write          (available_write[0]),
    .write_data_valid         (write_data_valid_q),
    .write_queue_id           (write_queue_id_q),
    .acc_user_request_write   (acc_user_request_write),
    .acc_user_write_data      (acc_user_write_data),
    .request_write            (request_write[0]),
    .write_data               (write_data[WR_W-1:0]),
    .has_wr_pending           (has_wr_pending),
    .acc_user_available_write (acc_user_available_write),
    .done                     (out_done)
  );

  stream_sum_kernel #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_kernel (
    .clk                      (clk),
    .arst_n                   (arst_n),
    .start                    (start_q),
    .acc_user_available_read  (acc_user_available_read),
    .acc_user_read_data       (acc_user_read_data),
    .acc_user_available_write (acc_user_available_write),
    .acc_user_request_read    (acc_user_request_read),
    .acc_user_request_write   (acc_user_request_write),
    .acc_user_write_data      (acc_user_write_data)
  );

  // Status port sits in the upper write slice.
  done_status_ctrl #(
    .DATA_WIDTH (DATA_WIDTH),
    .ACC_ID     (ACC_ID)
  ) u_done_status (
    .clk                (clk),
    .arst_n             (arst_n),
    .start              (start_q),
    .conf_valid         (conf_valid_q),
    .conf               (conf_q),
    .done_rd            (in_done),
    .done_wr            (out_done),
    .has_pending        (has_pending),
    .acc_req_rd_data_en (acc_user_request_read),
    .acc_req_wr_data_en (acc_user_request_write),
    .available_write    (available_write[1]),
    .write_data_valid   (write_data_valid_q),
    .write_queue_id     (write_queue_id_q),
    .request_write      (request_write[1]),
    .write_data         (write_data[2*WR_W-1:WR_W])
  );

endmodule

`default_nettype wire

//--- done_status_ctrl.sv
`default_nettype none

module done_status_ctrl
  import acc_conf_pkg::*;
  import acc_mem_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int ACC_ID     = 7
) (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               start,
  input  logic [1:0]                         conf_valid,
  input  conf_word_t                         conf,
  input  logic                               done_rd,
  input  logic                               done_wr,
  input  logic                               has_pending,
  input  logic                               acc_req_rd_data_en,
  input  logic                               acc_req_wr_data_en,
  input  logic                               available_write,
  input  logic                               write_data_valid,
  input  tag_t                               write_queue_id,
  output logic                               request_write,
  output logic [DATA_WIDTH+ADDR_W+TAG_W-1:0] write_data
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_WAIT = 2'd1;
  localparam logic [1:0] ST_SEND = 2'd2;
  localparam logic [1:0] ST_ACK  = 2'd3;

  logic [1:0]              state;
  logic [ADDR_W-1:0]       status_addr;
  logic [STAT_FIELD_W-1:0] rd_beats;
  logic [STAT_FIELD_W-1:0] wr_beats;
  logic [STAT_W-1:0]       status_rec;

  assign status_rec    = {STAT_FIELD_W'(ACC_ID), rd_beats, wr_beats};
  // A 32-bit data path keeps only the two beat counts.
  assign write_data    = {DATA_WIDTH'(status_rec), status_addr, tag_t'(ACC_ID)};
  assign request_write = (state == ST_SEND) && available_write;

  always_ff @(posedge clk) begin
    if (conf_valid[CONF_DSM_BIT]) begin
      status_addr <= conf.dsm_conf.status_addr;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      rd_beats <= '0;
      wr_beats <= '0;
    end else if (start) begin
      state    <= ST_WAIT;
      rd_beats <= '0;
      wr_beats <= '0;
    end else begin
      if (acc_req_rd_data_en) begin
        rd_beats <= rd_beats + 1'b1;
      end
      if (acc_req_wr_data_en) begin
        wr_beats <= wr_beats + 1'b1;
      end
      case (state)
        ST_WAIT: if (done_rd && done_wr && !has_pending) state <= ST_SEND;
        ST_SEND: if (request_write) state <= ST_ACK;
        ST_ACK:  if (write_data_valid && (write_queue_id == tag_t'(ACC_ID))) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
acc_conf_pkg.sv
acc_mem_pkg.sv
input_queue_ctrl.sv
output_queue_ctrl.sv
stream_sum_kernel.sv
done_status_ctrl.sv
acc_top.sv
tb_acc_top.sv

//--- input_queue_ctrl.sv
`default_nettype none

module input_queue_ctrl
  import acc_conf_pkg::*;
  import acc_mem_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int ID_QUEUE   = 0
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    start,
  input  logic [1:0]              conf_valid,
  input  conf_word_t              conf,
  input  logic                    available_read,
  input  logic                    read_data_valid,
  input  tag_t                    read_queue_id,
  input  logic [DATA_WIDTH-1:0]   read_data,
  input  logic                    acc_user_request_read,
  output logic                    request_read,
  output logic [TAG_W+ADDR_W-1:0] request_data,
  output logic                    has_rd_pending,
  output logic                    acc_user_available_read,
  output logic [DATA_WIDTH-1:0]   acc_user_read_data,
  output logic                    done
);

  localparam logic [ADDR_W-1:0] WORD_BYTES = ADDR_W'(DATA_WIDTH / 8);
  localparam int PTR_W = 2;
  localparam int DEPTH = 2 ** PTR_W;

  logic [ADDR_W-1:0]     base_addr;
  logic [QTD_W-1:0]      count;
  logic                  conf_hit;
  logic                  rsp_hit;
  logic                  armed;
  logic [ADDR_W-1:0]     rd_addr;
  logic [QTD_W-1:0]      req_cnt;
  logic [QTD_W-1:0]      rsp_cnt;
  logic [QTD_W-1:0]      pull_cnt;
  logic [QTD_W-1:0]      in_flight;
  logic [DATA_WIDTH-1:0] buf_mem [DEPTH];

  assign conf_hit = conf_valid[CONF_QUEUE_BIT] &&
                    (conf.queue_conf.queue_id == 16'(ID_QUEUE));
  assign rsp_hit  = read_data_valid && (read_queue_id == tag_t'(ID_QUEUE));

  // A request holds its credit until the kernel has pulled the word.
  assign in_flight = req_cnt - pull_cnt;

  assign request_read = armed && (req_cnt != count) && available_read &&
                        (in_flight < QTD_W'(DEPTH));
  assign request_data = {tag_t'(ID_QUEUE), rd_addr};

  assign has_rd_pending          = req_cnt != rsp_cnt;
  assign acc_user_available_read = rsp_cnt != pull_cnt;
  assign acc_user_read_data      = buf_mem[pull_cnt[PTR_W-1:0]];
  assign done                    = armed && (pull_cnt == count);

  always_ff @(posedge clk) begin
    if (conf_hit) begin
      base_addr <= conf.queue_conf.base_addr;
      count     <= conf.queue_conf.count;
    end
    // Responses come back in order, so the response count is the write slot.
    if (rsp_hit) begin
      buf_mem[rsp_cnt[PTR_W-1:0]] <= read_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      armed    <= 1'b0;
      rd_addr  <= '0;
      req_cnt  <= '0;
      rsp_cnt  <= '0;
      pull_cnt <= '0;
    end else if (start) begin
      armed    <= 1'b1;
      rd_addr  <= base_addr;
      req_cnt  <= '0;
      rsp_cnt  <= '0;
      pull_cnt <= '0;
    end else begin
      // A new configuration ends the previous run.
      if (conf_hit) begin
        armed <= 1'b0;
      end
      if (request_read) begin
        rd_addr <= rd_addr + WORD_BYTES;
        req_cnt <= req_cnt + 1'b1;
      end
      if (rsp_hit) begin
        rsp_cnt <= rsp_cnt + 1'b1;
      end
      if (acc_user_request_read) begin
        pull_cnt <= pull_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- output_queue_ctrl.sv
`default_nettype none

module output_queue_ctrl
  import acc_conf_pkg::*;
  import acc_mem_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int ID_QUEUE   = 1
) (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               start,
  input  logic [1:0]                         conf_valid,
  input  conf_word_t                         conf,
  input  logic                               available_write,
  input  logic                               write_data_valid,
  input  tag_t                               write_queue_id,
  input  logic                               acc_user_request_write,
  input  logic [DATA_WIDTH-1:0]              acc_user_write_data,
  output logic                               request_write,
  output logic [DATA_WIDTH+ADDR_W+TAG_W-1:0] write_data,
  output logic                               has_wr_pending,
  output logic                               acc_user_available_write,
  output logic                               done
);

  localparam logic [ADDR_W-1:0] WORD_BYTES = ADDR_W'(DATA_WIDTH / 8);
  localparam int PTR_W = 2;
  localparam int DEPTH = 2 ** PTR_W;

  logic [ADDR_W-1:0]     base_addr;
  logic [QTD_W-1:0]      count;
  logic                  conf_hit;
  logic                  ack_hit;
  logic                  armed;
  logic [ADDR_W-1:0]     wr_addr;
  logic [QTD_W-1:0]      push_cnt;
  logic [QTD_W-1:0]      sent_cnt;
  logic [QTD_W-1:0]      ack_cnt;
  logic [QTD_W-1:0]      used;
  logic [DATA_WIDTH-1:0] buf_mem [DEPTH];

  assign conf_hit = conf_valid[CONF_QUEUE_BIT] &&
                    (conf.queue_conf.queue_id == 16'(ID_QUEUE));
  assign ack_hit  = write_data_valid && (write_queue_id == tag_t'(ID_QUEUE));

  // A slot is taken from the push until the write is acknowledged.
  assign used                     = push_cnt - ack_cnt;
  assign acc_user_available_write = used < QTD_W'(DEPTH);

  assign request_write  = armed && (sent_cnt != push_cnt) && available_write;
  assign write_data     = {buf_mem[sent_cnt[PTR_W-1:0]], wr_addr, tag_t'(ID_QUEUE)};
  assign has_wr_pending = sent_cnt != ack_cnt;
  assign done           = armed && (ack_cnt == count);

  always_ff @(posedge clk) begin
    if (conf_hit) begin
      base_addr <= conf.queue_conf.base_addr;
      count     <= conf.queue_conf.count;
    end
    if (acc_user_request_write) begin
      buf_mem[push_cnt[PTR_W-1:0]] <= acc_user_write_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      armed    <= 1'b0;
      wr_addr  <= '0;
      push_cnt <= '0;
      sent_cnt <= '0;
      ack_cnt  <= '0;
    end else if (start) begin
      armed    <= 1'b1;
      wr_addr  <= base_addr;
      push_cnt <= '0;
      sent_cnt <= '0;
      ack_cnt  <= '0;
    end else begin
      if (conf_hit) begin
        armed <= 1'b0;
      end
      if (acc_user_request_write) begin
        push_cnt <= push_cnt + 1'b1;
      end
      if (request_write) begin
        wr_addr  <= wr_addr + WORD_BYTES;
        sent_cnt <= sent_cnt + 1'b1;
      end
      if (ack_hit) begin
        ack_cnt <= ack_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- stream_sum_kernel.sv
`default_nettype none

module stream_sum_kernel #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  start,
  input  logic                  acc_user_available_read,
  input  logic [DATA_WIDTH-1:0] acc_user_read_data,
  input  logic                  acc_user_available_write,
  output logic                  acc_user_request_read,
  output logic                  acc_user_request_write,
  output logic [DATA_WIDTH-1:0] acc_user_write_data
);

  logic                  push_q;
  logic [DATA_WIDTH-1:0] acc;

  // No pull while a result is still on its way out.
  // The output space seen at pull time then still holds at the push.
  assign acc_user_request_read  = acc_user_available_read && acc_user_available_write &&
                                  !push_q;
  assign acc_user_request_write = push_q;
  assign acc_user_write_data    = acc;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      push_q <= 1'b0;
      acc    <= '0;
    end else if (start) begin
      push_q <= 1'b0;
      acc    <= '0;
    end else begin
      push_q <= acc_user_request_read;
      // Wraps modulo 2**DATA_WIDTH.
      if (acc_user_request_read) begin
        acc <= acc + acc_user_read_data;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_acc_top.sv
`default_nettype none

module tb_acc_top
  import acc_conf_pkg::*;
  import acc_mem_pkg::*;
();

  localparam int DATA_WIDTH   = 32;
  localparam int ACC_ID       = 7;
  localparam int IN_QUEUE_ID  = 0;
  localparam int OUT_QUEUE_ID = 1;
  localparam int WR_W         = DATA_WIDTH + ADDR_W + TAG_W;
  localparam int RUNS         = 3;
  localparam int MAX_WORDS    = 12;

  logic                    clk = 1'b0;
  logic                    arst_n;
  logic                    start;
  logic [1:0]              conf_valid;
  conf_word_t              conf;
  logic                    available_read = 1'b0;
  logic                    request_read;
  logic [TAG_W+ADDR_W-1:0] request_data;
  logic                    read_data_valid = 1'b0;
  tag_t                    read_queue_id = '0;
  logic [DATA_WIDTH-1:0]   read_data = '0;
  logic [1:0]              available_write = 2'b00;
  logic [1:0]              request_write;
  logic [2*WR_W-1:0]       write_data;
  logic                    write_data_valid = 1'b0;
  tag_t                    write_queue_id = '0;
  logic [WR_W-1:0]         data_wr;
  logic [WR_W-1:0]         stat_wr;

  // Memory model state.
  integer          seed = 73180;
  int              cycle = 0;
  int              limit = 1000;
  logic [31:0]     mem [256];
  logic [7:0]      rd_idx_q [$];
  tag_t            rd_tag_q [$];
  int              rd_due_q [$];
  tag_t            ack_tag_q [$];
  int              ack_due_q [$];
  int              data_ack_total = 0;
  int              stat_ack_total = 0;

  // Reference model and bookkeeping.
  int              rd_total = 0;
  int              wr_total = 0;
  int              stat_total = 0;
  int              rd_base, wr_base, stat_base, ack_base, stat_ack_base;
  bit              run_active = 1'b0;
  int              exp_count = 0;
  logic [31:0]     exp_in_base, exp_out_base, exp_stat_addr, exp_status;
  logic [31:0]     exp_sum [16];
  int              errors = 0;
  int              tests_passed = 0;
  int              tests_failed = 0;
  string           test_name = "";

  acc_top #(
    .DATA_WIDTH   (DATA_WIDTH),
    .ACC_ID       (ACC_ID),
    .IN_QUEUE_ID  (IN_QUEUE_ID),
    .OUT_QUEUE_ID (OUT_QUEUE_ID)
  ) dut0 (
    .clk              (clk),
    .arst_n           (arst_n),
    .start            (start),
    .conf_valid       (conf_valid),
    .conf             (conf),
    .available_read   (available_read),
    .request_read     (request_read),
    .request_data     (request_data),
    .read_data_valid  (read_data_valid),
    .read_queue_id    (read_queue_id),
    .read_data        (read_data),
    .available_write  (available_write),
    .request_write    (request_write),
    .write_data       (write_data),
    .write_data_valid (write_data_valid),
    .write_queue_id   (write_queue_id)
  );

  assign data_wr = write_data[WR_W-1:0];
  assign stat_wr = write_data[2*WR_W-1:WR_W];

  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("Mismatch in %s, %s: expected %0h, actual %0h", test_name, name,
               expected, actual);
    end
  endtask

  task automatic note_error(input string msg);
    errors++;
    $display("Error at cycle %0d: %s", cycle, msg);
  endtask

  task automatic end_test(input string name, input int err0);
    if (errors == err0) begin
      tests_passed++;
      $display("Test %s: PASS", name);
    end else begin
      tests_failed++;
      $display("Test %s: FAIL (%0d errors)", name, errors - err0);
    end
  endtask

  function automatic int random_delay();
    return 1 + int'($unsigned($random(seed)) % 6);
  endfunction

  function automatic conf_word_t queue_word(input logic [31:0] base, input int n,
                                            input int qid);
    conf_word_t w;
    w = '0;
    w.queue_conf.base_addr = base;
    w.queue_conf.count     = 16'(n);
    w.queue_conf.queue_id  = 16'(qid);
    return w;
  endfunction

  // **********************************************************************
  // Request monitor and memory model.
  // **********************************************************************

  always @(posedge clk) begin
    int k;
    cycle           <= cycle + 1;
    available_read  <= 1'($random(seed));
    available_write <= 2'($random(seed));
    if (!run_active && (request_read || request_write != 2'b00))
      note_error("request while no run is active");
    if ((request_read && !available_read) || (request_write & ~available_write) != 2'b00)
      note_error("request while the memory was not available");
    if (request_read) begin
      k = rd_total - rd_base;
      if (k >= exp_count) begin
        note_error("more read requests than the configured count");
      end else begin
        check_value("read_addr", 64'(exp_in_base + 32'(k * 4)), 64'(request_data[31:0]));
      end
      check_value("read_tag", 64'(IN_QUEUE_ID), 64'(request_data[39:32]));
      rd_idx_q.push_back(request_data[9:2]);
      rd_tag_q.push_back(request_data[39:32]);
      rd_due_q.push_back(cycle + random_delay());
      rd_total++;
    end
    if (request_write[0]) begin
      k = wr_total - wr_base;
      if (k >= exp_count) begin
        note_error("more data writes than the configured count");
      end else begin
        check_value("write_addr", 64'(exp_out_base + 32'(k * 4)), 64'(data_wr[39:8]));
        check_value("write_data", 64'(exp_sum[4'(k)]), 64'(data_wr[71:40]));
      end
      check_value("write_tag", 64'(OUT_QUEUE_ID), 64'(data_wr[7:0]));
      ack_tag_q.push_back(data_wr[7:0]);
      ack_due_q.push_back(cycle + random_delay());
      wr_total++;
    end
    if (request_write[1]) begin
      check_value("status_addr", 64'(exp_stat_addr), 64'(stat_wr[39:8]));
      check_value("status_data", 64'(exp_status), 64'(stat_wr[71:40]));
      check_value("status_tag", 64'(ACC_ID), 64'(stat_wr[7:0]));
      check_value("acks_before_status", 64'(exp_count), 64'(data_ack_total - ack_base));
      ack_tag_q.push_back(stat_wr[7:0]);
      ack_due_q.push_back(cycle + random_delay());
      stat_total++;
    end
    // Answers leave in request order.
    if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
      read_data_valid <= 1'b1;
      read_queue_id   <= rd_tag_q[0];
      read_data       <= mem[rd_idx_q[0]];
      void'(rd_due_q.pop_front());
      void'(rd_tag_q.pop_front());
      void'(rd_idx_q.pop_front());
    end else begin
      read_data_valid <= 1'b0;
    end
    if (ack_due_q.size() > 0 && ack_due_q[0] <= cycle) begin
      write_data_valid <= 1'b1;
      write_queue_id   <= ack_tag_q[0];
      if (ack_tag_q[0] == tag_t'(OUT_QUEUE_ID))
        data_ack_total++;
      if (ack_tag_q[0] == tag_t'(ACC_ID))
        stat_ack_total++;
      void'(ack_due_q.pop_front());
      void'(ack_tag_q.pop_front());
    end else begin
      write_data_valid <= 1'b0;
    end
  end

  always @(posedge clk) begin
    if (cycle >= limit) begin
      $display("Timeout: the runs did not finish within %0d cycles", limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // **********************************************************************
  // Runs.
  // **********************************************************************

  task automatic do_run(input int r, input int n);
    int               in_idx;
    int               i;
    int               err0;
    logic [31:0]      sum;
    logic [STAT_W-1:0] stat_rec;
    conf_word_t       w;
    in_idx = int'($unsigned($random(seed)) % 128);
    @(negedge clk);
    test_name     = $sformatf("run%0d (count %0d)", r, n);
    exp_count     = n;
    exp_in_base   = 32'h1000_0000 + 32'(in_idx * 4);
    exp_out_base  = 32'h2000_0000 + 32'(($unsigned($random(seed)) % 256) * 4);
    exp_stat_addr = 32'h3000_0000 + 32'(r * 64);
    stat_rec      = {16'(ACC_ID), 16'(n), 16'(n)};
    exp_status    = stat_rec[DATA_WIDTH-1:0];
    sum = '0;
    for (i = 0; i < n; i++) begin
      sum = sum + mem[8'(in_idx + i)];
      exp_sum[4'(i)] = sum;
    end
    err0          = errors;
    rd_base       = rd_total;
    wr_base       = wr_total;
    stat_base     = stat_total;
    ack_base      = data_ack_total;
    stat_ack_base = stat_ack_total;
    run_active    = 1'b1;
    w = '0;
    w.dsm_conf.status_addr = exp_stat_addr;
    @(posedge clk);
    conf_valid <= 2'b01;
    conf       <= queue_word(exp_in_base, n, IN_QUEUE_ID);
    @(posedge clk);
    conf       <= queue_word(exp_out_base, n, OUT_QUEUE_ID);
    @(posedge clk);
    conf_valid <= 2'b10;
    conf       <= w;
    @(posedge clk);
    conf_valid <= 2'b00;
    start      <= 1'b1;
    @(posedge clk);
    start      <= 1'b0;
    @(negedge clk);
    while (stat_ack_total == stat_ack_base)
      @(negedge clk);
    repeat (3) @(negedge clk);
    check_value("read_count", 64'(n), 64'(rd_total - rd_base));
    check_value("write_count", 64'(n), 64'(wr_total - wr_base));
    check_value("status_writes", 64'(1), 64'(stat_total - stat_base));
    run_active = 1'b0;
    end_test(test_name, err0);
  endtask

  initial begin
    int counts [RUNS];
    int total;
    int r;
    int err0;
    arst_n     = 1'b0;
    start      = 1'b0;
    conf_valid = 2'b00;
    conf       = '0;
    for (r = 0; r < 256; r++)
      mem[8'(r)] = $random(seed);
    total = 0;
    for (r = 0; r < RUNS; r++)
      counts[r] = 1 + int'($unsigned($random(seed)) % MAX_WORDS);
    // The middle run has no words at all.
    counts[1] = 0;
    for (r = 0; r < RUNS; r++)
      total = total + counts[r];
    limit = 200 * total + 500;
    test_name = "reset_idle";
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    err0 = errors;
    repeat (8) @(negedge clk);
    end_test(test_name, err0);
    for (r = 0; r < RUNS; r++)
      do_run(r, counts[r]);
    $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
